/* Bender.yml */
package:
  name: cache_top

sources:
  - hdl/cache_cfg_pkg.sv
  - hdl/cache_ctrl_pkg.sv
  - hdl/cache_ctrl.sv
  - hdl/cache_tag_array.sv
  - hdl/cache_data_array.sv
  - hdl/cache_top.sv
  - target: simulation
    files:
      - sim/slow_mem.sv
      - sim/cache_assertions.sv
      - sim/tb_cache.sv

/* hdl/cache_cfg_pkg.sv */
// cache geometry and data types
`default_nettype none

package cache_cfg_pkg;

	// -------------------------------------------------------------------------
	// word and line geometry
	// -------------------------------------------------------------------------
	localparam int WORD_BITS = 32;
	localparam int WORDS_PER_LINE = 4;
	localparam int LINE_BITS = WORD_BITS * WORDS_PER_LINE; // 128-bit line
	localparam int WORD_OFFSET_BITS = $clog2(WORDS_PER_LINE); // word select in a line

	// address widths
	localparam int PROC_ADDR_BITS = 30; // word address
	localparam int MEM_ADDR_BITS = PROC_ADDR_BITS - WORD_OFFSET_BITS; // line address

	localparam int DEFAULT_SET_BITS = 2; // four sets

	// -------------------------------------------------------------------------
	// data types
	// -------------------------------------------------------------------------
	typedef logic [WORD_BITS-1:0] word_t;
	typedef logic [PROC_ADDR_BITS-1:0] proc_addr_t;
	typedef logic [MEM_ADDR_BITS-1:0] mem_addr_t;

	// one cache line
	// raw towards memory, word indexed towards the processor
	typedef union packed {
		logic [LINE_BITS-1:0] raw;
		word_t [WORDS_PER_LINE-1:0] words; // words[0] sits at bits 31:0
	} line_t;

	// tag is what is left of the word address above set index and word offset
	function automatic int tag_width(input int set_bits);
		return PROC_ADDR_BITS - set_bits - WORD_OFFSET_BITS;
	endfunction

endpackage

`default_nettype wire

/* hdl/cache_ctrl.sv */
// cache miss controller
`default_nettype none

module cache_ctrl #(
	parameter int set_bits = cache_cfg_pkg::DEFAULT_SET_BITS
) (
	input  logic                                          clk,
	input  logic                                          proc_reset,

	// processor side
	input  logic                                          proc_read,
	input  logic                                          proc_write,
	input  cache_cfg_pkg::proc_addr_t                     proc_addr,
	output logic                                          proc_stall,

	// from the arrays
	input  logic                                          hit,
	input  logic                                          victim_dirty,
	input  logic [cache_cfg_pkg::tag_width(set_bits)-1:0] victim_tag,
	input  cache_cfg_pkg::line_t                          victim_line,

	// to the arrays
	output cache_ctrl_pkg::array_cmd_t                    array_cmd,

	// memory side
	output logic                                          mem_read,
	output logic                                          mem_write,
	output cache_cfg_pkg::mem_addr_t                      mem_addr,
	output cache_cfg_pkg::line_t                          mem_wdata,
	input  logic                                          mem_ready
);

	cache_ctrl_pkg::cache_state_t state;
	cache_ctrl_pkg::cache_state_t state_nxt;

	logic request;
	logic [set_bits-1:0] set_idx;
	cache_cfg_pkg::mem_addr_t fill_addr;
	cache_cfg_pkg::mem_addr_t victim_addr;

	// -------------------------------------------------------------------------
	// address forming
	// -------------------------------------------------------------------------
	assign request = proc_read | proc_write;
	assign set_idx = proc_addr[cache_cfg_pkg::WORD_OFFSET_BITS +: set_bits];

	// line holding the requested word
	assign fill_addr = proc_addr[cache_cfg_pkg::PROC_ADDR_BITS-1:cache_cfg_pkg::WORD_OFFSET_BITS];

	// victim goes back to where it came from
	assign victim_addr = {victim_tag, set_idx};

	assign mem_wdata = victim_line; // sampled by memory only while mem_write

	// -------------------------------------------------------------------------
	// state register
	// -------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			state <= cache_ctrl_pkg::s_idle;
		end else begin
			state <= state_nxt;
		end
	end

	// -------------------------------------------------------------------------
	// next state and outputs
	// -------------------------------------------------------------------------
	always_comb begin
		state_nxt = state;
		proc_stall = 1'b1;
		mem_read = 1'b0;
		mem_write = 1'b0;
		mem_addr = fill_addr;
		array_cmd = cache_ctrl_pkg::cmd_none;

		unique case (state)
			cache_ctrl_pkg::s_idle: begin
				state_nxt = cache_ctrl_pkg::s_compare;
			end

			cache_ctrl_pkg::s_compare: begin
				if (!request) begin
					proc_stall = 1'b0; // nothing to serve
				end else if (hit) begin
					proc_stall = 1'b0;
					if (proc_write) begin
						array_cmd = cache_ctrl_pkg::cmd_hit_write;
					end
				end else if (victim_dirty) begin
					state_nxt = cache_ctrl_pkg::s_write_back;
				end else begin
					state_nxt = cache_ctrl_pkg::s_allocate; // clean or empty victim
				end
			end

			cache_ctrl_pkg::s_write_back: begin
				mem_write = 1'b1;
				mem_addr = victim_addr;
				if (mem_ready) begin
					array_cmd = cache_ctrl_pkg::cmd_clean;
					state_nxt = cache_ctrl_pkg::s_allocate;
				end
			end

			cache_ctrl_pkg::s_allocate: begin
				mem_read = 1'b1;
				if (mem_ready) begin
					array_cmd = cache_ctrl_pkg::cmd_fill; // mem_rdata valid this cycle
					state_nxt = cache_ctrl_pkg::s_compare; // completes there as a hit
				end
			end
		endcase
	end

endmodule

`default_nettype wire

/* hdl/cache_ctrl_pkg.sv */
// cache controller types
`default_nettype none

package cache_ctrl_pkg;

	// miss handling states
	typedef enum logic [1:0] {
		s_compare    = 2'b00, // tag check, hits complete here
		s_write_back = 2'b01, // dirty victim out to memory
		s_allocate   = 2'b10, // line fill from memory
		s_idle       = 2'b11  // single cycle after reset
	} cache_state_t;

	// update command from the controller to both arrays
	// way selection is implied by the command
	typedef enum logic [1:0] {
		cmd_none      = 2'b00,
		cmd_hit_write = 2'b01, // merge word into hit way, mark dirty
		cmd_clean     = 2'b10, // victim written back, clear dirty
		cmd_fill      = 2'b11  // new line into victim way
	} array_cmd_t;

endpackage

`default_nettype wire

/* hdl/cache_data_array.sv */
// cache data array
`default_nettype none

module cache_data_array #(
	parameter int set_bits = cache_cfg_pkg::DEFAULT_SET_BITS
) (
	input  logic                       clk,
	input  cache_cfg_pkg::proc_addr_t  proc_addr,
	input  cache_cfg_pkg::word_t       proc_wdata,
	input  cache_cfg_pkg::line_t       mem_rdata,
	input  cache_ctrl_pkg::array_cmd_t array_cmd,
	input  logic                       hit_way,
	input  logic                       victim_way,
	output cache_cfg_pkg::word_t       rd_word,
	output cache_cfg_pkg::line_t       victim_line
);

	localparam int num_sets = 1 << set_bits;

	cache_cfg_pkg::line_t lines_q [2][num_sets];

	logic [set_bits-1:0] set_idx;
	logic [$clog2(cache_cfg_pkg::WORDS_PER_LINE)-1:0] word_idx;
	cache_cfg_pkg::line_t hit_line;

	assign set_idx = proc_addr[cache_cfg_pkg::WORD_OFFSET_BITS +: set_bits];
	assign word_idx = proc_addr[cache_cfg_pkg::WORD_OFFSET_BITS-1:0];

	// -------------------------------------------------------------------------
	// reads
	// -------------------------------------------------------------------------
	assign hit_line = lines_q[hit_way][set_idx];
	assign rd_word = hit_line.words[word_idx]; // only meaningful on a hit

	// write-back source
	assign victim_line = lines_q[victim_way][set_idx];

	// -------------------------------------------------------------------------
	// writes
	// -------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (array_cmd == cache_ctrl_pkg::cmd_hit_write) begin
			// merge one word, rest of the line untouched
			lines_q[hit_way][set_idx].words[word_idx] <= proc_wdata;
		end else if (array_cmd == cache_ctrl_pkg::cmd_fill) begin
			lines_q[victim_way][set_idx].raw <= mem_rdata.raw; // whole line from memory
		end
	end

endmodule

`default_nettype wire

/* hdl/cache_tag_array.sv */
// cache tag array
`default_nettype none

module cache_tag_array #(
	parameter int set_bits = cache_cfg_pkg::DEFAULT_SET_BITS
) (
	input  logic                                          clk,
	input  logic                                          proc_reset,
	input  cache_cfg_pkg::proc_addr_t                     proc_addr,
	input  cache_ctrl_pkg::array_cmd_t                    array_cmd,
	output logic                                          hit,
	output logic                                          hit_way,
	output logic                                          victim_way,
	output logic                                          victim_dirty,
	output logic [cache_cfg_pkg::tag_width(set_bits)-1:0] victim_tag
);

	localparam int tag_bits = cache_cfg_pkg::tag_width(set_bits);
	localparam int num_sets = 1 << set_bits;

	logic [tag_bits-1:0] tag_q [2][num_sets];
	logic [num_sets-1:0] valid_q [2];
	logic [num_sets-1:0] dirty_q [2];
	logic [num_sets-1:0] lru_q; // way to replace next, per set

	logic [set_bits-1:0] set_idx;
	logic [tag_bits-1:0] addr_tag;
	logic [1:0] way_hit;

	assign set_idx = proc_addr[cache_cfg_pkg::WORD_OFFSET_BITS +: set_bits];
	assign addr_tag = proc_addr[cache_cfg_pkg::PROC_ADDR_BITS-1 -: tag_bits];

	// -------------------------------------------------------------------------
	// lookup
	// -------------------------------------------------------------------------
	always_comb begin
		for (int w = 0; w < 2; w++) begin
			way_hit[w] = valid_q[w][set_idx] && (tag_q[w][set_idx] == addr_tag);
		end
	end

	assign hit = |way_hit;
	assign hit_way = way_hit[1]; // a line lives in one way only

	assign victim_way = lru_q[set_idx];
	assign victim_dirty = dirty_q[victim_way][set_idx];
	assign victim_tag = tag_q[victim_way][set_idx];

	// -------------------------------------------------------------------------
	// state bits
	// -------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			for (int w = 0; w < 2; w++) begin
				valid_q[w] <= '0;
				dirty_q[w] <= '0;
			end
			lru_q <= '0;
		end else begin
			unique case (array_cmd)
				cache_ctrl_pkg::cmd_none: begin
					if (hit) begin
						lru_q[set_idx] <= ~hit_way; // read hit refreshes recency
					end
				end
				cache_ctrl_pkg::cmd_hit_write: begin
					dirty_q[hit_way][set_idx] <= 1'b1;
					lru_q[set_idx] <= ~hit_way;
				end
				cache_ctrl_pkg::cmd_clean: begin
					dirty_q[victim_way][set_idx] <= 1'b0;
				end
				cache_ctrl_pkg::cmd_fill: begin
					valid_q[victim_way][set_idx] <= 1'b1;
					dirty_q[victim_way][set_idx] <= 1'b0;
					lru_q[set_idx] <= ~victim_way; // other way goes next
				end
			endcase
		end
	end

	// tags change only on a fill
	always_ff @(posedge clk) begin
		if (array_cmd == cache_ctrl_pkg::cmd_fill) begin
			tag_q[victim_way][set_idx] <= addr_tag;
		end
	end

endmodule

`default_nettype wire

/* hdl/cache_top.sv */
// two-way write-back data cache
`default_nettype none

module cache_top #(
	parameter int set_bits = cache_cfg_pkg::DEFAULT_SET_BITS
) (
	input  logic                      clk,
	input  logic                      proc_reset,

	// processor side
	input  logic                      proc_read,
	input  logic                      proc_write,
	input  cache_cfg_pkg::proc_addr_t proc_addr,
	input  cache_cfg_pkg::word_t      proc_wdata,
	output cache_cfg_pkg::word_t      proc_rdata,
	output logic                      proc_stall,

	// memory side
	output logic                      mem_read,
	output logic                      mem_write,
	output cache_cfg_pkg::mem_addr_t  mem_addr,
	output cache_cfg_pkg::line_t      mem_wdata,
	input  cache_cfg_pkg::line_t      mem_rdata,
	input  logic                      mem_ready
);

	localparam int tag_bits = cache_cfg_pkg::tag_width(set_bits);

	// tag array results
	logic hit;
	logic hit_way;
	logic victim_way;
	logic victim_dirty;
	logic [tag_bits-1:0] victim_tag;

	cache_cfg_pkg::line_t victim_line;
	cache_ctrl_pkg::array_cmd_t array_cmd;

	// -------------------------------------------------------------------------
	// controller
	// -------------------------------------------------------------------------
	cache_ctrl #(
		.set_bits (set_bits)
	) u_ctrl (
		.clk          (clk),
		.proc_reset   (proc_reset),
		.proc_read    (proc_read),
		.proc_write   (proc_write),
		.proc_addr    (proc_addr),
		.proc_stall   (proc_stall),
		.hit          (hit),
		.victim_dirty (victim_dirty),
		.victim_tag   (victim_tag),
		.victim_line  (victim_line),
		.array_cmd    (array_cmd),
		.mem_read     (mem_read),
		.mem_write    (mem_write),
		.mem_addr     (mem_addr),
		.mem_wdata    (mem_wdata),
		.mem_ready    (mem_ready)
	);

	// -------------------------------------------------------------------------
	// arrays
	// -------------------------------------------------------------------------
	cache_tag_array #(
		.set_bits (set_bits)
	) u_tags (
		.clk          (clk),
		.proc_reset   (proc_reset),
		.proc_addr    (proc_addr),
		.array_cmd    (array_cmd),
		.hit          (hit),
		.hit_way      (hit_way),
		.victim_way   (victim_way),
		.victim_dirty (victim_dirty),
		.victim_tag   (victim_tag)
	);

	cache_data_array #(
		.set_bits (set_bits)
	) u_data (
		.clk         (clk),
		.proc_addr   (proc_addr),
		.proc_wdata  (proc_wdata),
		.mem_rdata   (mem_rdata),
		.array_cmd   (array_cmd),
		.hit_way     (hit_way),
		.victim_way  (victim_way),
		.rd_word     (proc_rdata), // read data straight to the processor
		.victim_line (victim_line)
	);

endmodule

`default_nettype wire

/* sim/cache_assertions.sv */
// cache memory protocol assertions
`default_nettype none

module cache_assertions (
	input logic                     clk,
	input logic                     proc_reset,
	input logic                     proc_stall,
	input logic                     mem_read,
	input logic                     mem_write,
	input cache_cfg_pkg::mem_addr_t mem_addr,
	input cache_cfg_pkg::line_t     mem_wdata,
	input logic                     mem_ready
);
	timeunit 1ns;
	timeprecision 1ps;

	int assert_errors = 0; // failures seen, read by the testbench

	one_request: assert property (@(posedge clk) disable iff (proc_reset)
		!(mem_read && mem_write))
	else begin
		assert_errors++;
		$error("mem_read and mem_write high together");
	end

	// request held until memory answers
	request_stable: assert property (@(posedge clk) disable iff (proc_reset)
		((mem_read || mem_write) && !mem_ready) |=>
		$stable({mem_read, mem_write, mem_addr, mem_wdata}))
	else begin
		assert_errors++;
		$error("memory request changed before mem_ready");
	end

	stall_after_reset: assert property (@(posedge clk) proc_reset |=> proc_stall)
	else begin
		assert_errors++;
		$error("proc_stall low in the cycle after reset");
	end

endmodule

bind cache_top cache_assertions u_assertions (
	.clk        (clk),
	.proc_reset (proc_reset),
	.proc_stall (proc_stall),
	.mem_read   (mem_read),
	.mem_write  (mem_write),
	.mem_addr   (mem_addr),
	.mem_wdata  (mem_wdata),
	.mem_ready  (mem_ready)
);

`default_nettype wire

/* sim/slow_mem.sv */
// behavioral line memory
`default_nettype none

module slow_mem (
	input  logic                     clk,
	input  logic                     proc_reset,
	input  logic                     mem_read,
	input  logic                     mem_write,
	input  cache_cfg_pkg::mem_addr_t mem_addr,
	input  cache_cfg_pkg::line_t     mem_wdata,
	output cache_cfg_pkg::line_t     mem_rdata,
	output logic                     mem_ready
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [31:0] lfsr_seed = 32'hc72574be;

	cache_cfg_pkg::line_t store [cache_cfg_pkg::mem_addr_t]; // lines written back so far
	logic [31:0] lfsr_q;
	logic [31:0] lfsr_nxt;
	logic busy;
	int wait_left;
	int read_count;
	int write_count;
	cache_cfg_pkg::mem_addr_t last_wr_addr;
	cache_cfg_pkg::line_t last_wr_line;

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// untouched lines hold their own word addresses
	function automatic cache_cfg_pkg::line_t initial_line(input cache_cfg_pkg::mem_addr_t a);
		cache_cfg_pkg::line_t l;
		for (int i = 0; i < cache_cfg_pkg::WORDS_PER_LINE; i++) begin
			l.words[i] = {a, 2'(i), 2'b10};
		end
		return l;
	endfunction

	assign lfsr_nxt = lfsr_step(lfsr_step(lfsr_q)); // two new bits per delay

	initial begin
		mem_ready = 1'b0;
		mem_rdata = '0;
	end

	always @(posedge clk) begin
		if (proc_reset) begin
			lfsr_q <= lfsr_seed;
			busy <= 1'b0;
			mem_ready <= 1'b0;
			read_count <= 0;
			write_count <= 0;
		end else if (mem_ready) begin
			mem_ready <= 1'b0; // old request still visible at this edge
		end else if (!busy && (mem_read || mem_write)) begin
			busy <= 1'b1;
			wait_left <= 1 + int'(lfsr_nxt[1:0]); // one to four cycles
			lfsr_q <= lfsr_nxt;
		end else if (busy && wait_left > 1) begin
			wait_left <= wait_left - 1;
		end else if (busy) begin
			busy <= 1'b0;
			mem_ready <= 1'b1;
			if (mem_write) begin
				store[mem_addr] = mem_wdata;
				write_count <= write_count + 1;
				last_wr_addr <= mem_addr;
				last_wr_line <= mem_wdata;
			end else begin
				mem_rdata <= store.exists(mem_addr) ? store[mem_addr] : initial_line(mem_addr);
				read_count <= read_count + 1;
			end
		end
	end

endmodule

`default_nettype wire

/* sim/tb_cache.sv */
// data cache testbench
`default_nettype none

module tb_cache;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int set_bits = cache_cfg_pkg::DEFAULT_SET_BITS;
	localparam int wait_limit = 100; // cycles per access

	logic clk;
	logic proc_reset;
	logic proc_read;
	logic proc_write;
	cache_cfg_pkg::proc_addr_t proc_addr;
	cache_cfg_pkg::word_t proc_wdata;
	cache_cfg_pkg::word_t proc_rdata;
	logic proc_stall;
	logic mem_read;
	logic mem_write;
	cache_cfg_pkg::mem_addr_t mem_addr;
	cache_cfg_pkg::line_t mem_wdata;
	cache_cfg_pkg::line_t mem_rdata;
	logic mem_ready;

	int mismatches = 0;
	int timeouts = 0;
	int base_reads;
	int base_writes;
	cache_cfg_pkg::word_t written [cache_cfg_pkg::proc_addr_t]; // processor stores so far

	function automatic cache_cfg_pkg::proc_addr_t make_addr(input int tag, input int set,
			input int word);
		return cache_cfg_pkg::proc_addr_t'((tag << (set_bits + 2)) | (set << 2) | word);
	endfunction

	// three tags in set 1
	localparam cache_cfg_pkg::proc_addr_t addr_a = make_addr('h12345, 1, 2);
	localparam cache_cfg_pkg::proc_addr_t addr_b = make_addr('h2abcd, 1, 0);
	localparam cache_cfg_pkg::proc_addr_t addr_c = make_addr('h3f00f, 1, 1);

	cache_top #(.set_bits(set_bits)) dut (.*);
	slow_mem mem (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ------------------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------------------
	function automatic cache_cfg_pkg::word_t expected_word(input cache_cfg_pkg::proc_addr_t addr);
		if (written.exists(addr)) begin
			return written[addr];
		end
		return {addr, 2'b10}; // memory contents before any write-back
	endfunction

	function automatic cache_cfg_pkg::line_t expected_line(input cache_cfg_pkg::proc_addr_t addr);
		cache_cfg_pkg::line_t l;
		for (int i = 0; i < cache_cfg_pkg::WORDS_PER_LINE; i++) begin
			l.words[i] = expected_word({addr[29:2], 2'(i)});
		end
		return l;
	endfunction

	// ------------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------------
	task automatic check_word(input string name, input cache_cfg_pkg::word_t got,
			input cache_cfg_pkg::word_t exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %h, expected %h", $time, name, got, exp);
			mismatches++;
		end
	endtask

	task automatic check_line(input string name, input cache_cfg_pkg::line_t got,
			input cache_cfg_pkg::line_t exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %h, expected %h", $time, name, got, exp);
			mismatches++;
		end
	endtask

	task automatic check_addr(input string name, input cache_cfg_pkg::mem_addr_t got,
			input cache_cfg_pkg::mem_addr_t exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %h, expected %h", $time, name, got, exp);
			mismatches++;
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("Mismatch at %0t: %s got %0d, expected %0d", $time, name, got, exp);
			mismatches++;
		end
	endtask

	task automatic mark_traffic();
		base_reads = mem.read_count;
		base_writes = mem.write_count;
	endtask

	task automatic check_traffic(input int reads, input int writes);
		check_count("memory reads", mem.read_count - base_reads, reads);
		check_count("memory writes", mem.write_count - base_writes, writes);
	endtask

	// ------------------------------------------------------------------------
	// processor accesses
	// ------------------------------------------------------------------------
	task automatic access(input logic wr, input cache_cfg_pkg::proc_addr_t addr,
			input cache_cfg_pkg::word_t wdata, output cache_cfg_pkg::word_t rdata,
			output int cycles);
		@(posedge clk);
		proc_read <= ~wr;
		proc_write <= wr;
		proc_addr <= addr;
		proc_wdata <= wdata;
		cycles = 0;
		@(negedge clk);
		while (proc_stall && cycles < wait_limit) begin
			@(negedge clk);
			cycles++;
		end
		if (proc_stall) begin
			$display("Timeout at %0t: cache still stalled after %0d cycles", $time, cycles);
			timeouts++;
		end
		rdata = proc_rdata;
		if (wr) begin
			written[addr] = wdata;
		end
		@(posedge clk); // a write is taken at this edge
		proc_read <= 1'b0;
		proc_write <= 1'b0;
	endtask

	task automatic read_expect(input cache_cfg_pkg::proc_addr_t addr, input logic is_hit);
		cache_cfg_pkg::word_t rd;
		int cycles;
		access(1'b0, addr, '0, rd, cycles);
		check_word("proc_rdata", rd, expected_word(addr));
		if (is_hit) begin
			check_count("proc_stall cycles on hit", cycles, 0); // hits add no cycle
		end
	endtask

	// ------------------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------------------
	task automatic cold_miss();
		mark_traffic();
		read_expect(addr_a, 1'b0);
		check_traffic(1, 0);
	endtask

	task automatic write_hit();
		cache_cfg_pkg::word_t rd;
		int cycles;
		mark_traffic();
		access(1'b1, addr_a, 32'hdead_beef, rd, cycles);
		check_count("proc_stall cycles on hit", cycles, 0);
		read_expect(addr_a, 1'b1);
		check_traffic(0, 0);
	endtask

	task automatic two_way_reuse();
		mark_traffic();
		read_expect(addr_b, 1'b0); // second tag, other way
		check_traffic(1, 0);
		mark_traffic();
		repeat (2) begin
			read_expect(addr_a, 1'b1);
			read_expect(addr_b, 1'b1);
		end
		check_traffic(0, 0); // a is now least recently used
	endtask

	task automatic dirty_eviction();
		mark_traffic();
		read_expect(addr_c, 1'b0);
		check_traffic(1, 1);
		check_addr("mem_addr of write-back", mem.last_wr_addr, addr_a[29:2]);
		check_line("mem_wdata of write-back", mem.last_wr_line, expected_line(addr_a));
	endtask

	task automatic refill_after_evict();
		mark_traffic();
		read_expect(addr_a, 1'b0); // clean victim b goes quietly
		check_traffic(1, 0);
	endtask

	initial begin
		proc_reset = 1'b1;
		proc_read = 1'b0;
		proc_write = 1'b0;
		proc_addr = '0;
		proc_wdata = '0;
		repeat (10) @(posedge clk);
		proc_reset <= 1'b0;

		cold_miss();
		write_hit();
		two_way_reuse();
		dirty_eviction();
		refill_after_evict();

		repeat (2) @(posedge clk);
		$display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
			mismatches, timeouts, dut.u_assertions.assert_errors);
		if (mismatches + timeouts + dut.u_assertions.assert_errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
hdl/cache_cfg_pkg.sv
hdl/cache_ctrl_pkg.sv
hdl/cache_ctrl.sv
hdl/cache_tag_array.sv
hdl/cache_data_array.sv
hdl/cache_top.sv
sim/slow_mem.sv
sim/cache_assertions.sv
sim/tb_cache.sv
